// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_icache
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation result: PASS"; \
	else \
	  echo "Simulation result: FAIL, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_bus_model.sv
// Burst memory model for the cache bus port
// Takes each line strobe after a random gap, then returns one word per
// ack in offset order. A word's data is its byte address with a key.

`include "icache_defs.svh"

module tb_bus_model #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              stb_i,
  input  icache_pkg::addr_t adr_i,
  output logic              stb_ack_o,
  output logic              ack_o,
  output icache_pkg::word_t q_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned WORD_BYTES = `ICACHE_WORD_W / 8;
  localparam icache_pkg::word_t DATA_KEY = 32'h5a5a_0000;

  logic [31:0]       rnd;
  icache_pkg::addr_t base;  // Line address of the current burst

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ----------------------------------------------------------------------
  // One burst per strobe, outputs change on the falling edge
  // ----------------------------------------------------------------------
  initial begin
    rnd       = SEED;
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    q_o       = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && stb_i) begin
        base = adr_i;
        rnd  = xorshift32(rnd);
        repeat (rnd[1:0]) @(negedge clk_i);  // 0 to 3 cycles before the ack
        stb_ack_o = 1'b1;
        @(negedge clk_i);
        stb_ack_o = 1'b0;
        for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
          rnd = xorshift32(rnd);
          repeat (rnd[1:0]) @(negedge clk_i);  // Gap between words
          ack_o = 1'b1;
          q_o   = (base + 32'(k * WORD_BYTES)) ^ DATA_KEY;
          @(negedge clk_i);
          ack_o = 1'b0;
          q_o   = rnd;  // Junk while not acked
        end
      end
    end
  end

endmodule

// File: dv/tb_icache.sv
// Testbench for the blocking direct-mapped instruction cache
// Random word requests over 32 lines plus occasional flushes. A tag
// model predicts hit or miss; assertions check parcels, bus strobes
// and flush length. A burst memory model answers line fetches.

`include "icache_defs.svh"

module tb_icache;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RST_CYCLES   = 4;
  localparam int unsigned N_REQ        = 400;
  localparam int unsigned CYC_PER_REQ  = 40;   // Watchdog budget per request
  localparam int unsigned PARCEL_LIMIT = 100;  // Cycles to wait for one parcel
  localparam int unsigned IDX_LSB      = `ICACHE_BYTE_BITS + `ICACHE_OFFS_BITS;
  localparam int unsigned TAG_LSB      = IDX_LSB + `ICACHE_IDX_BITS;
  localparam logic [31:0] SEED         = 32'hb23e_7c0d;
  localparam icache_pkg::addr_t BASE_ADR = 32'h0004_0000;
  localparam icache_pkg::word_t DATA_KEY = 32'h5a5a_0000;

  logic              clk;
  logic              rst_n;
  logic              req;
  icache_pkg::addr_t adr;
  logic              flush;
  logic              busy;
  icache_pkg::word_t parcel;
  logic              parcel_valid;
  logic              biu_stb;
  icache_pkg::addr_t biu_adri;
  logic              biu_stb_ack;
  logic              biu_ack;
  icache_pkg::word_t biu_q;

  // Reference tag model and request tracking
  logic [`ICACHE_SETS-1:0] mdl_valid;
  icache_pkg::tag_t        mdl_tag [`ICACHE_SETS];
  icache_pkg::idx_t        adr_idx;
  logic                    accept;
  logic                    cur_hit;    // Model says the live address hits
  logic                    looked_q;   // First lookup cycle after acceptance
  logic                    exp_hit_q;
  logic                    started_q;  // A request or flush has been seen
  icache_pkg::addr_t       acc_adr;
  icache_pkg::addr_t       last_adr;
  logic [31:0]             rnd;
  int                      err_cnt = 0;
  int                      n_req;
  int                      n_hit;
  int                      n_flush = 0;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bus data of a word is its byte address with a fixed key
  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
    return {a[`ICACHE_ADDR_W-1:`ICACHE_BYTE_BITS], {`ICACHE_BYTE_BITS{1'b0}}} ^ DATA_KEY;
  endfunction

  function automatic icache_pkg::addr_t line_base(input icache_pkg::addr_t a);
    return {a[`ICACHE_ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
  endfunction

  // 32 lines, one tag bit above the index, random word offset
  function automatic icache_pkg::addr_t make_adr(input logic [31:0] r);
    icache_pkg::addr_t a;
    a = BASE_ADR;
    a[IDX_LSB +: 5] = r[8:4];
    a[`ICACHE_BYTE_BITS +: `ICACHE_OFFS_BITS] = r[1:0];
    return a;
  endfunction

  function automatic void flag_error(input string msg);
    err_cnt++;
    $display("FAILED @%0t ns: %s", $time, msg);
  endfunction

  // ----------------------------------------------------------------------
  // DUT, bus model, clock and watchdog
  // ----------------------------------------------------------------------
  icache_top i_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_i          (req),
    .adr_i          (adr),
    .cache_flush_i  (flush),
    .busy_o         (busy),
    .parcel_o       (parcel),
    .parcel_valid_o (parcel_valid),
    .biu_stb_o      (biu_stb),
    .biu_adri_o     (biu_adri),
    .biu_stb_ack_i  (biu_stb_ack),
    .biu_ack_i      (biu_ack),
    .biu_q_i        (biu_q)
  );

  tb_bus_model #(.SEED(SEED)) u_bus (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .stb_i     (biu_stb),
    .adr_i     (biu_adri),
    .stb_ack_o (biu_stb_ack),
    .ack_o     (biu_ack),
    .q_o       (biu_q)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(N_REQ * CYC_PER_REQ * CLK_PERIOD);
    $display("Watchdog expired after %0d requests, the run did not finish", n_req);
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Tag model, updated on acceptance and flush
  // ----------------------------------------------------------------------
  assign accept  = req && !busy;
  assign adr_idx = adr[IDX_LSB +: `ICACHE_IDX_BITS];
  assign cur_hit = mdl_valid[adr_idx] && (mdl_tag[adr_idx] == adr[`ICACHE_ADDR_W-1:TAG_LSB]);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mdl_valid <= '0;
      looked_q  <= 1'b0;
      exp_hit_q <= 1'b0;
      started_q <= 1'b0;
      acc_adr   <= '0;
      n_req     <= 0;
      n_hit     <= 0;
    end else begin
      looked_q <= accept;
      if (req || flush) begin
        started_q <= 1'b1;
      end
      if (flush) begin
        mdl_valid <= '0;
      end
      if (accept) begin
        exp_hit_q          <= cur_hit;
        acc_adr            <= adr;
        mdl_valid[adr_idx] <= 1'b1;  // Present once this request is done
        mdl_tag[adr_idx]   <= adr[`ICACHE_ADDR_W-1:TAG_LSB];
        n_req              <= n_req + 1;
        n_hit              <= n_hit + (cur_hit ? 1 : 0);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !started_q |-> !busy && !parcel_valid && !biu_stb)
    else flag_error("outputs active before the first request");

  a_parcel: assert property (@(posedge clk) disable iff (!rst_n)
    parcel_valid |-> parcel == expected_word(acc_adr))
    else flag_error($sformatf("wrong parcel for address %h", acc_adr));

  a_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    parcel_valid |=> !parcel_valid)
    else flag_error("parcel_valid longer than one cycle");

  a_hit: assert property (@(posedge clk) disable iff (!rst_n)
    looked_q && exp_hit_q |-> parcel_valid && !biu_stb)
    else flag_error($sformatf("expected hit for address %h", acc_adr));

  a_miss: assert property (@(posedge clk) disable iff (!rst_n)
    looked_q && !exp_hit_q |-> !parcel_valid)
    else flag_error($sformatf("unexpected hit for address %h", acc_adr));

  a_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    looked_q && !exp_hit_q |=> biu_stb && (biu_adri == line_base(acc_adr)))
    else flag_error($sformatf("no line fetch for address %h", acc_adr));

  a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    biu_stb && !biu_stb_ack |=> biu_stb && $stable(biu_adri))
    else flag_error("bus strobe or address changed before the ack");

  a_stb_drop: assert property (@(posedge clk) disable iff (!rst_n)
    biu_stb && biu_stb_ack |=> !biu_stb)
    else flag_error("bus strobe still high after the ack");

  // ----------------------------------------------------------------------
  // Stimulus, called on a falling edge
  // ----------------------------------------------------------------------
  task automatic request(input icache_pkg::addr_t a);
    int waited;
    req = 1'b1;
    adr = a;
    while (busy) @(negedge clk);  // Held until the cache is idle
    @(negedge clk);
    rnd    = xorshift32(rnd);
    req    = 1'b0;
    adr    = rnd;  // Address only counts in the accept cycle
    waited = 0;
    while (!parcel_valid && waited < PARCEL_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!parcel_valid) begin
      err_cnt++;
      $display("Request to address %h never returned a parcel", a);
    end
    last_adr = a;
  endtask

  task automatic flush_cache();
    int run;
    while (busy) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    run   = 0;
    while (busy && run < 64) begin
      run++;
      @(negedge clk);
    end
    assert (run == `ICACHE_SETS)
      else flag_error($sformatf("flush kept busy high for %0d cycles", run));
    n_flush++;
  endtask

  initial begin
    int i;
    rst_n    = 1'b0;
    req      = 1'b0;
    adr      = '0;
    flush    = 1'b0;
    rnd      = SEED;
    last_adr = BASE_ADR;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);  // Outputs must stay quiet here
    for (i = 0; i < N_REQ; i++) begin
      rnd = xorshift32(rnd);
      if (rnd[31:28] == 4'h0) begin
        flush_cache();
        request(last_adr);  // Filled before the flush, must miss now
      end else begin
        request(make_adr(rnd));
      end
    end
    repeat (4) @(negedge clk);
    $display("Requests %0d, hits %0d, flushes %0d, errors %0d", n_req, n_hit, n_flush, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_step_cnt.sv
rtl/icache_tag_ram.sv
rtl/icache_data_ram.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
dv/tb_bus_model.sv
dv/tb_icache.sv

// File: rtl/icache_ctrl.sv
// Controller FSM of the blocking instruction cache
// Accepts one CPU request at a time and steers the tag and data arrays.
// A miss fetches the whole line as an incrementing burst, then the
// lookup repeats and hits. A flush waits for idle and walks every set.

`include "icache_defs.svh"

module icache_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  // CPU side
  input  logic               req_i,
  input  icache_pkg::addr_t  adr_i,
  input  logic               cache_flush_i,
  output logic               busy_o,
  output logic               parcel_valid_o,
  // Bus side
  output logic               biu_stb_o,
  output icache_pkg::addr_t  biu_adri_o,
  input  logic               biu_stb_ack_i,
  input  logic               biu_ack_i,
  // Arrays and step counter
  input  logic               hit_i,
  input  logic               last_word_i,
  input  logic               last_set_i,
  output icache_pkg::idx_t   rd_idx_o,
  output icache_pkg::offs_t  rd_offs_o,
  output icache_pkg::tag_t   cmp_tag_o,
  output logic               fill_we_o,
  output logic               tag_we_o,
  output logic               inval_o,
  output logic               cnt_clr_o,
  output logic               cnt_step_o
);

  icache_pkg::ctrl_state_e state_q, state_d;
  icache_pkg::addr_t       adr_q;         // Held request address
  icache_pkg::addr_t       lk_adr;        // Address under lookup
  logic                    flush_pend_q;  // Flush waiting for idle
  logic                    flush_start;
  logic                    accept;

  // ----------------------------------------------------------------------
  // Acceptance and flush pending
  // ----------------------------------------------------------------------
  // A pending flush counts as busy, so it wins over a request
  assign busy_o      = (state_q != icache_pkg::IDLE) || flush_pend_q;
  assign accept      = req_i && !busy_o;
  assign flush_start = (state_q == icache_pkg::IDLE) && flush_pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= icache_pkg::IDLE;
      flush_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      flush_pend_q <= cache_flush_i || (flush_pend_q && !flush_start);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q <= adr_i;  // Only valid in the accept cycle
    end
  end

  // Live address while idle, held one otherwise
  assign lk_adr    = (state_q == icache_pkg::IDLE) ? adr_i : adr_q;
  assign rd_idx_o  = lk_adr[`ICACHE_BYTE_BITS + `ICACHE_OFFS_BITS +: `ICACHE_IDX_BITS];
  assign rd_offs_o = lk_adr[`ICACHE_BYTE_BITS +: `ICACHE_OFFS_BITS];
  assign cmp_tag_o = lk_adr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_BITS];

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      icache_pkg::IDLE: begin
        if (flush_start) begin
          state_d = icache_pkg::FLUSH;  // Set 0 cleared on the way out
        end else if (accept) begin
          state_d = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        state_d = hit_i ? icache_pkg::IDLE : icache_pkg::BUS_REQ;
      end
      icache_pkg::BUS_REQ: begin
        if (biu_stb_ack_i) begin
          state_d = icache_pkg::FILL;
        end
      end
      icache_pkg::FILL: begin
        if (biu_ack_i && last_word_i) begin
          state_d = icache_pkg::LOOKUP;  // Re-lookup now hits
        end
      end
      icache_pkg::FLUSH: begin
        if (last_set_i) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: state_d = icache_pkg::IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign parcel_valid_o = (state_q == icache_pkg::LOOKUP) && hit_i;

  // Line-aligned burst start
  assign biu_stb_o  = (state_q == icache_pkg::BUS_REQ);
  assign biu_adri_o = {adr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFS_BITS + `ICACHE_BYTE_BITS],
                       {(`ICACHE_OFFS_BITS + `ICACHE_BYTE_BITS){1'b0}}};

  assign fill_we_o  = (state_q == icache_pkg::FILL) && biu_ack_i;  // One word per ack
  assign tag_we_o   = fill_we_o && last_word_i;                    // Line complete
  assign inval_o    = flush_start || (state_q == icache_pkg::FLUSH);

  // Counter starts from zero for both fill and flush
  assign cnt_clr_o  = (state_q == icache_pkg::LOOKUP) || (state_q == icache_pkg::BUS_REQ);
  assign cnt_step_o = fill_we_o || inval_o;

  // Strobe and line address hold until the bus takes the request
  a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_stb_o && !biu_stb_ack_i |=> biu_stb_o && $stable(biu_adri_o));

  // Re-lookup after a line fill always hits and returns the parcel
  a_parcel_lookup: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == icache_pkg::LOOKUP) && ($past(state_q) == icache_pkg::FILL)
    |-> parcel_valid_o);

endmodule

// File: rtl/icache_data_ram.sv
// Data word array of the cache
// One registered read port for lookups and one write port for burst
// fill words. Read output feeds the CPU parcel directly.

`include "icache_defs.svh"

module icache_data_ram (
  input  logic               clk_i,
  input  icache_pkg::idx_t   rd_idx_i,
  input  icache_pkg::offs_t  rd_offs_i,
  input  icache_pkg::idx_t   wr_idx_i,
  input  icache_pkg::offs_t  wr_offs_i,
  input  logic               we_i,       // Fill word strobe
  input  icache_pkg::word_t  wr_word_i,  // Burst data
  output icache_pkg::word_t  rd_word_o   // One cycle after the read
);

  localparam int unsigned ADDR_BITS = `ICACHE_IDX_BITS + `ICACHE_OFFS_BITS;

  icache_pkg::word_t      mem [`ICACHE_SETS * `ICACHE_LINE_WORDS];
  logic [ADDR_BITS-1:0]   rd_addr;
  logic [ADDR_BITS-1:0]   wr_addr;

  // Word address is set then offset
  assign rd_addr = {rd_idx_i, rd_offs_i};
  assign wr_addr = {wr_idx_i, wr_offs_i};

  // ----------------------------------------------------------------------
  // Write and read ports
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[wr_addr] <= wr_word_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i && (wr_addr == rd_addr)) begin
      rd_word_o <= wr_word_i;  // Last fill word bypass
    end else begin
      rd_word_o <= mem[rd_addr];
    end
  end

endmodule

// File: rtl/icache_defs.svh
// Geometry of the direct-mapped instruction cache
// Included by the package and by every RTL module that slices addresses
// or sizes an array. Derived bit counts follow from the base sizes.

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ----------------------------------------------------------------------
// Base sizes
// ----------------------------------------------------------------------
`define ICACHE_ADDR_W     32  // Byte address
`define ICACHE_WORD_W     32  // Instruction and bus data word
`define ICACHE_SETS       16  // Lines in the cache
`define ICACHE_LINE_WORDS 4   // Words per line, also burst length

// ----------------------------------------------------------------------
// Derived bit counts
// ----------------------------------------------------------------------
`define ICACHE_IDX_BITS  ($clog2(`ICACHE_SETS))
`define ICACHE_OFFS_BITS ($clog2(`ICACHE_LINE_WORDS))
`define ICACHE_BYTE_BITS ($clog2(`ICACHE_WORD_W / 8))
// Whatever is left above index, offset and byte
`define ICACHE_TAG_BITS  (`ICACHE_ADDR_W - `ICACHE_IDX_BITS - `ICACHE_OFFS_BITS - `ICACHE_BYTE_BITS)

`endif

// File: rtl/icache_pkg.sv
// Types shared by the instruction cache modules
// Vector widths come from the geometry defines; refer to the types
// with scoped names from each module.

`include "icache_defs.svh"

package icache_pkg;

  // ----------------------------------------------------------------------
  // Vectors with a meaning
  // ----------------------------------------------------------------------
  typedef logic [`ICACHE_ADDR_W-1:0]    addr_t;  // Byte address
  typedef logic [`ICACHE_WORD_W-1:0]    word_t;  // Instruction or bus word
  typedef logic [`ICACHE_TAG_BITS-1:0]  tag_t;   // Line tag
  typedef logic [`ICACHE_IDX_BITS-1:0]  idx_t;   // Set index
  typedef logic [`ICACHE_OFFS_BITS-1:0] offs_t;  // Word in line

  // ----------------------------------------------------------------------
  // Controller FSM
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    IDLE,     // Waiting for a request or a pending flush
    LOOKUP,   // Registered tag/data read is valid
    BUS_REQ,  // Line fetch strobe out
    FILL,     // Collecting burst words
    FLUSH     // Walking the sets
  } ctrl_state_e;

endpackage

// File: rtl/icache_step_cnt.sv
// Step counter shared by line fill and flush
// The low offset bits count burst words; the full width walks the sets.
// End flags are decoded here for the controller.

`include "icache_defs.svh"

module icache_step_cnt (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clr_i,        // Back to zero
  input  logic              step_i,       // Count one word or set
  output icache_pkg::idx_t  cnt_o,
  output logic              last_word_o,  // Last word of a line
  output logic              last_set_o    // Last set of the cache
);

  icache_pkg::idx_t cnt_q;

  // ----------------------------------------------------------------------
  // Counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (step_i) begin
      cnt_q <= cnt_q + 1'b1;  // Wraps to zero after the last set
    end
  end

  assign cnt_o = cnt_q;

  // End flags
  assign last_word_o = &cnt_q[`ICACHE_OFFS_BITS-1:0];
  assign last_set_o  = &cnt_q;

  // Controller never clears and steps in the same cycle
  a_clr_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clr_i && step_i));

endmodule

// File: rtl/icache_tag_ram.sv
// Tag and valid array of the direct-mapped cache
// Synchronous read with the compare tag registered alongside, so the
// hit flag is valid the cycle after the read index is presented.
// Tag writes land on the line under lookup; flush clears by wr_idx_i.

`include "icache_defs.svh"

module icache_tag_ram (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  icache_pkg::idx_t  rd_idx_i,   // Lookup set
  input  icache_pkg::tag_t  cmp_tag_i,  // Lookup tag, also the fill tag
  input  icache_pkg::idx_t  wr_idx_i,   // Set to invalidate
  input  logic              tag_we_i,   // Line filled
  input  logic              inval_i,    // Clear one valid bit
  output logic              hit_o
);

  icache_pkg::tag_t        tag_mem [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0] valid_q;
  icache_pkg::tag_t        tag_rd_q;
  icache_pkg::tag_t        cmp_tag_q;
  logic                    valid_rd_q;

  // ----------------------------------------------------------------------
  // Valid bits and registered valid read
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      valid_rd_q <= 1'b0;
    end else begin
      if (inval_i) begin
        valid_q[wr_idx_i] <= 1'b0;
      end else if (tag_we_i) begin
        valid_q[rd_idx_i] <= 1'b1;
      end
      // Write-first, so the re-lookup after a fill sees the new line
      if (tag_we_i) begin
        valid_rd_q <= 1'b1;
      end else if (inval_i && (wr_idx_i == rd_idx_i)) begin
        valid_rd_q <= 1'b0;
      end else begin
        valid_rd_q <= valid_q[rd_idx_i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Tag store and registered tag read
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_mem[rd_idx_i] <= cmp_tag_i;
    end
    tag_rd_q  <= tag_we_i ? cmp_tag_i : tag_mem[rd_idx_i];
    cmp_tag_q <= cmp_tag_i;
  end

  assign hit_o = valid_rd_q && (tag_rd_q == cmp_tag_q);

  // Fill and flush never overlap
  a_we_inval: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tag_we_i && inval_i));

endmodule

// File: rtl/icache_top.sv
// Top level of the blocking direct-mapped instruction cache
// Connects the controller, step counter and both arrays to the CPU
// request port and the burst bus port.

`include "icache_defs.svh"

module icache_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // CPU side
  input  logic               req_i,
  input  icache_pkg::addr_t  adr_i,
  input  logic               cache_flush_i,
  output logic               busy_o,
  output icache_pkg::word_t  parcel_o,
  output logic               parcel_valid_o,
  // Bus side
  output logic               biu_stb_o,
  output icache_pkg::addr_t  biu_adri_o,
  input  logic               biu_stb_ack_i,
  input  logic               biu_ack_i,
  input  icache_pkg::word_t  biu_q_i
);

  icache_pkg::idx_t  rd_idx;
  icache_pkg::offs_t rd_offs;
  icache_pkg::tag_t  cmp_tag;
  icache_pkg::idx_t  cnt;
  logic              fill_we;
  logic              tag_we;
  logic              inval;
  logic              cnt_clr;
  logic              cnt_step;
  logic              last_word;
  logic              last_set;
  logic              hit;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .adr_i          (adr_i),
    .cache_flush_i  (cache_flush_i),
    .busy_o         (busy_o),
    .parcel_valid_o (parcel_valid_o),
    .biu_stb_o      (biu_stb_o),
    .biu_adri_o     (biu_adri_o),
    .biu_stb_ack_i  (biu_stb_ack_i),
    .biu_ack_i      (biu_ack_i),
    .hit_i          (hit),
    .last_word_i    (last_word),
    .last_set_i     (last_set),
    .rd_idx_o       (rd_idx),
    .rd_offs_o      (rd_offs),
    .cmp_tag_o      (cmp_tag),
    .fill_we_o      (fill_we),
    .tag_we_o       (tag_we),
    .inval_o        (inval),
    .cnt_clr_o      (cnt_clr),
    .cnt_step_o     (cnt_step)
  );

  icache_step_cnt u_step_cnt (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clr_i       (cnt_clr),
    .step_i      (cnt_step),
    .cnt_o       (cnt),
    .last_word_o (last_word),
    .last_set_o  (last_set)
  );

  // ----------------------------------------------------------------------
  // Arrays
  // ----------------------------------------------------------------------
  icache_tag_ram u_tag_ram (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_idx_i  (rd_idx),
    .cmp_tag_i (cmp_tag),
    .wr_idx_i  (cnt),      // Flush walk
    .tag_we_i  (tag_we),
    .inval_i   (inval),
    .hit_o     (hit)
  );

  icache_data_ram u_data_ram (
    .clk_i     (clk_i),
    .rd_idx_i  (rd_idx),
    .rd_offs_i (rd_offs),
    .wr_idx_i  (rd_idx),                          // Fill line is the held one
    .wr_offs_i (cnt[`ICACHE_OFFS_BITS-1:0]),  // Burst word number
    .we_i      (fill_we),
    .wr_word_i (biu_q_i),
    .rd_word_o (parcel_o)
  );

endmodule
